/* dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DC_NUM_WAYS   2
`define DC_NUM_SETS   16
`define DC_LINE_BYTES 16
`define DC_LINE_WORDS 4
`define DC_ADDR_W     32

// Address field widths derived from the geometry
`define DC_WAY_W  $clog2(`DC_NUM_WAYS)
`define DC_SET_W  $clog2(`DC_NUM_SETS)
`define DC_WSEL_W $clog2(`DC_LINE_WORDS)
`define DC_OFFS_W $clog2(`DC_LINE_BYTES)
`define DC_TAG_W  (`DC_ADDR_W - `DC_SET_W - `DC_OFFS_W)

`endif

/* dcache_pkg.sv */
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [31:0]                    dc_word_t;
    typedef logic [3:0]                     dc_strb_t;
    typedef logic [`DC_LINE_WORDS*32-1:0]   dc_line_t;
    typedef logic [`DC_TAG_W-1:0]           dc_tag_t;
    typedef logic [`DC_SET_W-1:0]           dc_set_t;
    typedef logic [`DC_WAY_W-1:0]           dc_way_t;
    typedef logic [`DC_WSEL_W-1:0]          dc_wsel_t;

    // Byte address split into its cache fields, tag on top
    typedef struct packed {
        dc_tag_t    tag;
        dc_set_t    set_idx;
        dc_wsel_t   wsel;
        logic [1:0] boff;
    } dc_addr_t;

    typedef struct packed {
        logic     store;
        dc_strb_t strb;
        dc_addr_t addr;
        dc_word_t wdata;
    } dc_req_t;

    // Memory side channels, always INCR bursts of full lines
    typedef struct packed {
        dc_addr_t araddr;
        logic     arvalid;
    } axi_ar_t;

    typedef struct packed {
        dc_word_t rdata;
        logic     rlast;
        logic     rvalid;
    } axi_r_t;

    typedef struct packed {
        dc_addr_t awaddr;
        logic     awvalid;
    } axi_aw_t;

    typedef struct packed {
        dc_word_t wdata;
        logic     wlast;
        logic     wvalid;
    } axi_w_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_DATA,
        FILL_WRITE
    } dc_fill_state_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA
    } dc_wb_state_t;

endpackage

`default_nettype wire

/* dcache_tags.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_tags (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire dcache_pkg::dc_addr_t lookup,
    input  wire logic                 fill_en,
    input  wire dcache_pkg::dc_set_t  fill_set,
    input  wire dcache_pkg::dc_tag_t  fill_tag,
    input  wire dcache_pkg::dc_way_t  victim_way,
    output logic                      hit,
    output dcache_pkg::dc_way_t       hit_way,
    output dcache_pkg::dc_tag_t       victim_tag
);

    dcache_pkg::dc_tag_t                          tag_mem [`DC_NUM_WAYS][`DC_NUM_SETS];
    logic [`DC_NUM_WAYS-1:0][`DC_NUM_SETS-1:0]    valid;
    logic [`DC_NUM_WAYS-1:0]                      way_hit;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[victim_way][fill_set] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[victim_way][fill_set] <= 1'b1;
        end
    end

    // Compare every way, then fold the match into a way number
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `DC_NUM_WAYS; i++) begin
            way_hit[i] = valid[i][lookup.set_idx] && (tag_mem[i][lookup.set_idx] == lookup.tag);
            if (way_hit[i]) begin
                hit_way = hit_way | dcache_pkg::dc_way_t'(i);
            end
        end
    end

    assign hit        = |way_hit;
    assign victim_tag = tag_mem[victim_way][fill_set];

    // Refill only follows a miss, so a line never lives in two ways
    one_way_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

`default_nettype wire

/* dcache_lines.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_lines (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire dcache_pkg::dc_set_t  rd_set,
    input  wire dcache_pkg::dc_way_t  rd_way,
    input  wire logic                 victim_rd,
    input  wire dcache_pkg::dc_set_t  victim_set,
    input  wire dcache_pkg::dc_way_t  victim_way,
    input  wire logic                 wr_en,
    input  wire dcache_pkg::dc_set_t  wr_set,
    input  wire dcache_pkg::dc_way_t  wr_way,
    input  wire dcache_pkg::dc_line_t wr_line,
    input  wire logic                 store_mark,
    input  wire logic                 dirty_clear,
    output dcache_pkg::dc_line_t      rd_line,
    output dcache_pkg::dc_line_t      victim_line,
    output logic                      victim_dirty
);

    dcache_pkg::dc_line_t                         line_mem [`DC_NUM_WAYS][`DC_NUM_SETS];
    logic [`DC_NUM_WAYS-1:0][`DC_NUM_SETS-1:0]    dirty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_way][wr_set] <= wr_line;
        end
    end

    // Lookup read, a write to the same slot this cycle is forwarded
    always_ff @(posedge clk) begin
        if (wr_en && (wr_set == rd_set) && (wr_way == rd_way)) begin
            rd_line <= wr_line;
        end else begin
            rd_line <= line_mem[rd_way][rd_set];
        end
    end

    // Victim copy stays put for the whole writeback
    always_ff @(posedge clk) begin
        if (victim_rd) begin
            victim_line <= line_mem[victim_way][victim_set];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty <= '0;
        end else begin
            if (store_mark) begin
                dirty[wr_way][wr_set] <= 1'b1;
            end
            if (dirty_clear) begin
                dirty[victim_way][victim_set] <= 1'b0;
            end
        end
    end

    assign victim_dirty = dirty[victim_way][victim_set];

endmodule

`default_nettype wire

/* dcache_store_merge.sv */
`default_nettype none

module dcache_store_merge (
    input  wire logic                 clk,
    input  wire logic                 req_valid,
    input  wire logic                 hit,
    input  wire dcache_pkg::dc_req_t  req,
    input  wire dcache_pkg::dc_way_t  hit_way,
    input  wire dcache_pkg::dc_line_t rd_line,
    output dcache_pkg::dc_word_t      resp_data,
    output logic                      wr_en,
    output dcache_pkg::dc_set_t       wr_set,
    output dcache_pkg::dc_way_t       wr_way,
    output dcache_pkg::dc_line_t      wr_line
);

    dcache_pkg::dc_word_t st_data;
    dcache_pkg::dc_strb_t st_strb;
    dcache_pkg::dc_wsel_t wsel_q;
    dcache_pkg::dc_word_t old_word;
    dcache_pkg::dc_word_t new_word;

    // Pending store, written into the array on the following cycle
    always_ff @(posedge clk) begin
        wr_en   <= req_valid && hit && req.store;
        wr_set  <= req.addr.set_idx;
        wr_way  <= hit_way;
        wsel_q  <= req.addr.wsel;
        st_strb <= req.strb;
        st_data <= req.wdata;
    end

    // The line arrives one cycle after lookup, same as the word select
    assign old_word  = rd_line[wsel_q*32 +: 32];
    assign resp_data = old_word;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            new_word[b*8 +: 8] = st_strb[b] ? st_data[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

    always_comb begin
        wr_line = rd_line;
        wr_line[wsel_q*32 +: 32] = new_word;
    end

endmodule

`default_nettype wire

/* dcache_burst_data.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_burst_data (
    input  wire logic                 clk,
    input  wire dcache_pkg::axi_r_t   r,
    input  wire dcache_pkg::dc_line_t victim_line,
    input  wire logic                 wvalid,
    input  wire logic                 wready,
    output dcache_pkg::dc_line_t      fill_line,
    output dcache_pkg::dc_word_t      wdata
);

    dcache_pkg::dc_wsel_t widx;

    // Lowest word comes first, so beats enter at the top and move down
    always_ff @(posedge clk) begin
        if (r.rvalid) begin
            fill_line <= {r.rdata, fill_line[`DC_LINE_WORDS*32-1:32]};
        end
    end

    // Word index restarts whenever no burst is active
    always_ff @(posedge clk) begin
        if (!wvalid) begin
            widx <= '0;
        end else if (wready) begin
            widx <= widx + dcache_pkg::dc_wsel_t'(1);
        end
    end

    assign wdata = victim_line[widx*32 +: 32];

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 req_valid,
    input  wire dcache_pkg::dc_addr_t req_addr,
    input  wire logic                 hit,
    input  wire logic                 victim_dirty,
    input  wire dcache_pkg::dc_tag_t  victim_tag,
    input  wire logic                 arready,
    input  wire logic                 rvalid,
    input  wire logic                 rlast,
    input  wire logic                 awready,
    input  wire logic                 wready,
    output logic                      ready,
    output logic                      resp_miss,
    output logic                      resp_valid,
    output dcache_pkg::axi_ar_t       ar,
    output logic                      awvalid,
    output dcache_pkg::dc_addr_t      awaddr,
    output logic                      wvalid,
    output logic                      wlast,
    output logic                      fill_en,
    output logic                      victim_rd,
    output dcache_pkg::dc_set_t       fill_set,
    output dcache_pkg::dc_tag_t       fill_tag,
    output dcache_pkg::dc_way_t       victim_way,
    output logic                      dirty_clear
);

    dcache_pkg::dc_fill_state_t fill_state;
    dcache_pkg::dc_wb_state_t   wb_state;
    dcache_pkg::dc_addr_t       miss_addr;
    dcache_pkg::dc_way_t        rr_way;
    dcache_pkg::dc_way_t        wb_way;
    dcache_pkg::dc_wsel_t       beat;
    logic                       arvalid;
    logic                       miss;
    logic                       fill_idle;
    logic                       wb_idle;

    assign fill_idle = (fill_state == dcache_pkg::FILL_IDLE);
    assign wb_idle   = (wb_state == dcache_pkg::WB_IDLE);
    assign miss      = req_valid && !hit;
    assign resp_miss = miss;
    assign ready     = fill_idle && wb_idle;

    assign ar        = '{araddr: miss_addr, arvalid: arvalid};
    assign fill_set  = miss_addr.set_idx;
    assign fill_tag  = miss_addr.tag;
    assign fill_en   = (fill_state == dcache_pkg::FILL_WRITE);
    assign victim_rd = (fill_state == dcache_pkg::FILL_ADDR);

    // The counter moves on at refill, so a running writeback keeps its own way
    assign victim_way  = wb_idle ? rr_way : wb_way;
    assign wlast       = (wb_state == dcache_pkg::WB_DATA) &&
                         (beat == dcache_pkg::dc_wsel_t'(`DC_LINE_WORDS - 1));
    assign dirty_clear = wvalid && wready && wlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid && hit;
        end
    end

    // Refill
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_state <= dcache_pkg::FILL_IDLE;
            arvalid    <= 1'b0;
            rr_way     <= '0;
        end else begin
            case (fill_state)
                dcache_pkg::FILL_IDLE: begin
                    if (miss && wb_idle) begin
                        arvalid    <= 1'b1;
                        fill_state <= dcache_pkg::FILL_ADDR;
                    end
                end
                dcache_pkg::FILL_ADDR: begin
                    if (arready) begin
                        arvalid    <= 1'b0;
                        fill_state <= dcache_pkg::FILL_DATA;
                    end
                end
                dcache_pkg::FILL_DATA: begin
                    if (rvalid && rlast) begin
                        fill_state <= dcache_pkg::FILL_WRITE;
                    end
                end
                default: begin
                    rr_way     <= rr_way + dcache_pkg::dc_way_t'(1);
                    fill_state <= dcache_pkg::FILL_IDLE;
                end
            endcase
        end
    end

    // Line-aligned miss address, held through the refill
    always_ff @(posedge clk) begin
        if (fill_idle && miss) begin
            miss_addr <= '{tag: req_addr.tag, set_idx: req_addr.set_idx, wsel: '0, boff: '0};
        end
    end

    // Writeback of a dirty victim, started by the refill that replaces it
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_state <= dcache_pkg::WB_IDLE;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
        end else begin
            case (wb_state)
                dcache_pkg::WB_IDLE: begin
                    if (fill_en && victim_dirty) begin
                        awvalid  <= 1'b1;
                        wb_state <= dcache_pkg::WB_ADDR;
                    end
                end
                dcache_pkg::WB_ADDR: begin
                    if (awready) begin
                        awvalid  <= 1'b0;
                        wvalid   <= 1'b1;
                        wb_state <= dcache_pkg::WB_DATA;
                    end
                end
                default: begin
                    if (wready && wlast) begin
                        wvalid   <= 1'b0;
                        wb_state <= dcache_pkg::WB_IDLE;
                    end
                end
            endcase
        end
    end

    // Old tag is still in the store during the refill cycle
    always_ff @(posedge clk) begin
        if (fill_en) begin
            wb_way <= rr_way;
            awaddr <= '{tag: victim_tag, set_idx: fill_set, wsel: '0, boff: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (wb_state != dcache_pkg::WB_DATA) begin
            beat <= '0;
        end else if (wready) begin
            beat <= beat + dcache_pkg::dc_wsel_t'(1);
        end
    end

    // Read request stays up with a fixed address until memory takes it
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(miss_addr));

    aw_w_excl: assert property (@(posedge clk) disable iff (rst)
        !(awvalid && wvalid));

endmodule

`default_nettype wire

/* dcache_top.sv */
`default_nettype none

module dcache_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req_valid,
    input  wire dcache_pkg::dc_req_t req,
    output logic                     ready,
    output logic                     resp_miss,
    output logic                     resp_valid,
    output dcache_pkg::dc_word_t     resp_data,
    output dcache_pkg::axi_ar_t      ar,
    input  wire logic                arready,
    input  wire dcache_pkg::axi_r_t  r,
    output dcache_pkg::axi_aw_t      aw,
    input  wire logic                awready,
    output dcache_pkg::axi_w_t       w,
    input  wire logic                wready
);

    logic                  hit;
    logic                  victim_dirty;
    logic                  fill_en;
    logic                  victim_rd;
    logic                  dirty_clear;
    logic                  awvalid;
    logic                  wvalid;
    logic                  wlast;
    logic                  st_wr_en;
    logic                  wr_en;
    dcache_pkg::dc_way_t   hit_way;
    dcache_pkg::dc_way_t   victim_way;
    dcache_pkg::dc_way_t   st_wr_way;
    dcache_pkg::dc_way_t   wr_way;
    dcache_pkg::dc_tag_t   victim_tag;
    dcache_pkg::dc_tag_t   fill_tag;
    dcache_pkg::dc_set_t   fill_set;
    dcache_pkg::dc_set_t   st_wr_set;
    dcache_pkg::dc_set_t   wr_set;
    dcache_pkg::dc_addr_t  awaddr;
    dcache_pkg::dc_word_t  wdata;
    dcache_pkg::dc_line_t  rd_line;
    dcache_pkg::dc_line_t  victim_line;
    dcache_pkg::dc_line_t  fill_line;
    dcache_pkg::dc_line_t  st_wr_line;
    dcache_pkg::dc_line_t  wr_line;

    assign aw = '{awaddr: awaddr, awvalid: awvalid};
    assign w  = '{wdata: wdata, wlast: wlast, wvalid: wvalid};

    // Refill and store merge share the array write port, they never overlap
    assign wr_en   = fill_en | st_wr_en;
    assign wr_set  = fill_en ? fill_set : st_wr_set;
    assign wr_way  = fill_en ? victim_way : st_wr_way;
    assign wr_line = fill_en ? fill_line : st_wr_line;

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_addr(req.addr), .hit(hit),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .arready(arready), .rvalid(r.rvalid), .rlast(r.rlast),
        .awready(awready), .wready(wready),
        .ready(ready), .resp_miss(resp_miss), .resp_valid(resp_valid),
        .ar(ar), .awvalid(awvalid), .awaddr(awaddr),
        .wvalid(wvalid), .wlast(wlast),
        .fill_en(fill_en), .victim_rd(victim_rd),
        .fill_set(fill_set), .fill_tag(fill_tag),
        .victim_way(victim_way), .dirty_clear(dirty_clear)
    );

    dcache_tags u_tags (
        .clk(clk), .rst(rst),
        .lookup(req.addr),
        .fill_en(fill_en), .fill_set(fill_set), .fill_tag(fill_tag),
        .victim_way(victim_way),
        .hit(hit), .hit_way(hit_way), .victim_tag(victim_tag)
    );

    dcache_lines u_lines (
        .clk(clk), .rst(rst),
        .rd_set(req.addr.set_idx), .rd_way(hit_way),
        .victim_rd(victim_rd), .victim_set(fill_set), .victim_way(victim_way),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_line(wr_line),
        .store_mark(st_wr_en), .dirty_clear(dirty_clear),
        .rd_line(rd_line), .victim_line(victim_line), .victim_dirty(victim_dirty)
    );

    dcache_store_merge u_merge (
        .clk(clk),
        .req_valid(req_valid), .hit(hit), .req(req), .hit_way(hit_way),
        .rd_line(rd_line), .resp_data(resp_data),
        .wr_en(st_wr_en), .wr_set(st_wr_set), .wr_way(st_wr_way), .wr_line(st_wr_line)
    );

    dcache_burst_data u_burst (
        .clk(clk),
        .r(r), .victim_line(victim_line),
        .wvalid(wvalid), .wready(wready),
        .fill_line(fill_line), .wdata(wdata)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`default_nettype none

`include "dcache_config.svh"

module tb_axi_mem (
    input  wire logic                clk,
    input  wire dcache_pkg::axi_ar_t ar,
    output logic                     arready,
    output dcache_pkg::axi_r_t       r,
    input  wire dcache_pkg::axi_aw_t aw,
    output logic                     awready,
    input  wire dcache_pkg::axi_w_t  w,
    output logic                     wready
);
    timeunit 1ns;
    timeprecision 100ps;

    // Word storage keyed by word address
    logic [31:0] mem [logic [29:0]];
    integer      seed;

    // Words never written read back a pattern of their own address
    function automatic logic [31:0] peek(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[7:0], a[31:8]} ^ a ^ 32'h5A5A_0F0F;
    endfunction

    initial begin : read_side
        logic [31:0] base;
        seed    = 79086;
        arready = 1'b0;
        r       = '0;
        forever begin
            @(posedge clk);
            #1;
            if (ar.arvalid) begin
                base = ar.araddr;
                repeat ({$random(seed)} % 4) begin
                    @(posedge clk);
                    #1;
                end
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                    repeat ({$random(seed)} % 2) begin
                        @(posedge clk);
                        #1;
                    end
                    r = '{rdata: peek(base + 32'(4 * i)), rlast: (i == `DC_LINE_WORDS - 1),
                          rvalid: 1'b1};
                    @(posedge clk);
                    #1;
                    r = '0;
                end
            end
        end
    end

    initial begin : write_side
        logic [31:0] base;
        int          n;
        awready = 1'b0;
        wready  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (aw.awvalid) begin
                base = aw.awaddr;
                repeat ({$random(seed)} % 4) begin
                    @(posedge clk);
                    #1;
                end
                awready = 1'b1;
                @(posedge clk);
                #1;
                awready = 1'b0;
                n = 0;
                // Beat counts as taken once wready meets wvalid before the edge
                while (n < `DC_LINE_WORDS) begin
                    wready = ({$random(seed)} % 4) != 0;
                    if (wready && w.wvalid) begin
                        mem[base[31:2] + 30'(n)] = w.wdata;
                        n++;
                    end
                    @(posedge clk);
                    #1;
                end
                wready = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`default_nettype none

`include "dcache_config.svh"

module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RANDOM  = 200;
    localparam int NUM_REQ     = NUM_RANDOM + 12;
    localparam int MISS_CYCLES = 60;
    localparam int CYCLE_LIMIT = NUM_REQ * MISS_CYCLES;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid;
    dcache_pkg::dc_req_t  req;
    logic                 ready, resp_miss, resp_valid;
    dcache_pkg::dc_word_t resp_data;
    dcache_pkg::axi_ar_t  ar;
    dcache_pkg::axi_r_t   r;
    dcache_pkg::axi_aw_t  aw;
    dcache_pkg::axi_w_t   w;
    logic                 arready, awready, wready;

    // Expected values that go with the current request
    logic                 exp_miss, exp_load, exp_wb_pending;
    dcache_pkg::dc_word_t exp_word;
    dcache_pkg::dc_addr_t exp_fill_addr, exp_wb_addr;
    dcache_pkg::dc_word_t exp_wb_line [`DC_LINE_WORDS];

    // Reference model of the cache contents
    dcache_pkg::dc_tag_t  ref_tag   [`DC_NUM_WAYS][`DC_NUM_SETS];
    bit                   ref_valid [`DC_NUM_WAYS][`DC_NUM_SETS];
    bit                   ref_dirty [`DC_NUM_WAYS][`DC_NUM_SETS];
    int                   ref_rr;
    logic [31:0]          ref_word [logic [29:0]];

    integer seed;
    int     errors = 0;
    int     req_count = 0;
    int     cycles = 0;
    int     wbeat = 0;
    int     aw_count = 0;

    always #2 clk = ~clk;

    dcache_top dut0 (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .ready(ready), .resp_miss(resp_miss), .resp_valid(resp_valid), .resp_data(resp_data),
        .ar(ar), .arready(arready), .r(r), .aw(aw), .awready(awready), .w(w), .wready(wready)
    );

    tb_axi_mem mem0 (
        .clk(clk), .ar(ar), .arready(arready), .r(r),
        .aw(aw), .awready(awready), .w(w), .wready(wready)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (aw.awvalid && awready) begin
            wbeat    <= 0;
            aw_count <= aw_count + 1;
        end else if (w.wvalid && wready) begin
            wbeat <= wbeat + 1;
        end
        if (cycles > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic note_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    reset_state: assert property (@(posedge clk) $fell(rst) |->
        ready && !ar.arvalid && !aw.awvalid && !w.wvalid && !resp_valid && !resp_miss)
        else note_error("outputs not idle after reset");
    miss_flag: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> resp_miss == exp_miss) else note_error("hit/miss differs from model");
    miss_resp: assert property (@(posedge clk) disable iff (rst)
        req_valid && resp_miss |=> !ready && !resp_valid)
        else note_error("miss not followed by ready low");
    hit_resp: assert property (@(posedge clk) disable iff (rst)
        req_valid && !resp_miss |=> resp_valid && (!$past(exp_load) || resp_data == $past(exp_word)))
        else note_error("hit response or load data wrong");
    no_extra_resp: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(req_valid && !resp_miss)) else note_error("resp_valid without hit");
    ar_addr: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid |-> ar.araddr == exp_fill_addr) else note_error("read burst address wrong");
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
        else note_error("ar dropped before handshake");
    aw_expected: assert property (@(posedge clk) disable iff (rst)
        aw.awvalid |-> exp_wb_pending && aw.awaddr == exp_wb_addr)
        else note_error("unexpected writeback or wrong victim address");
    aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw.awvalid && !awready |=> aw.awvalid && $stable(aw.awaddr))
        else note_error("aw dropped before handshake");
    w_beat: assert property (@(posedge clk) disable iff (rst)
        w.wvalid && wready |-> w.wdata == exp_wb_line[wbeat] &&
        w.wlast == (wbeat == `DC_LINE_WORDS - 1)) else note_error("write beat data or wlast wrong");
    w_stable: assert property (@(posedge clk) disable iff (rst)
        w.wvalid && !wready |=> w.wvalid && $stable(w.wdata) && $stable(w.wlast))
        else note_error("w beat changed before handshake");

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        if (ref_word.exists(a[31:2])) begin
            return ref_word[a[31:2]];
        end
        return mem0.peek(a);
    endfunction

    function automatic bit line_dirty(input dcache_pkg::dc_addr_t ad);
        for (int i = 0; i < `DC_NUM_WAYS; i++) begin
            if (ref_valid[i][ad.set_idx] && ref_tag[i][ad.set_idx] == ad.tag &&
                ref_dirty[i][ad.set_idx]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // One request cycle driven just after the clock edge
    task automatic issue(input dcache_pkg::dc_req_t q, input logic miss,
                         input dcache_pkg::dc_word_t d);
        req_count++;
        req       = q;
        req_valid = 1'b1;
        exp_miss  = miss;
        exp_load  = !q.store && !miss;
        exp_word  = d;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic access(input logic st, input dcache_pkg::dc_strb_t strb,
                          input logic [31:0] a, input dcache_pkg::dc_word_t d);
        dcache_pkg::dc_addr_t ad;
        dcache_pkg::dc_req_t  q;
        dcache_pkg::dc_word_t word;
        int                   way;
        int                   aw_before;
        bit                   hit;
        ad  = a;
        q   = '{store: st, strb: strb, addr: ad, wdata: d};
        hit = 1'b0;
        way = 0;
        for (int i = 0; i < `DC_NUM_WAYS; i++) begin
            if (ref_valid[i][ad.set_idx] && ref_tag[i][ad.set_idx] == ad.tag) begin
                hit = 1'b1;
                way = i;
            end
        end
        if (!hit) begin
            way            = ref_rr;
            exp_fill_addr  = '{tag: ad.tag, set_idx: ad.set_idx, wsel: '0, boff: '0};
            exp_wb_pending = ref_valid[way][ad.set_idx] && ref_dirty[way][ad.set_idx];
            exp_wb_addr    = '{tag: ref_tag[way][ad.set_idx], set_idx: ad.set_idx,
                               wsel: '0, boff: '0};
            for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                exp_wb_line[i] = ref_read(exp_wb_addr + 32'(4 * i));
            end
            aw_before = aw_count;
            issue(q, 1'b1, '0);
            while (!ready) begin
                @(posedge clk);
                #1;
            end
            assert (aw_count - aw_before == int'(exp_wb_pending) &&
                    (!exp_wb_pending || wbeat == `DC_LINE_WORDS))
                else note_error("dirty victim writeback missing or incomplete");
            ref_tag[way][ad.set_idx]   = ad.tag;
            ref_valid[way][ad.set_idx] = 1'b1;
            ref_dirty[way][ad.set_idx] = 1'b0;
            ref_rr                     = (ref_rr + 1) % `DC_NUM_WAYS;
        end
        word = ref_read(a);
        issue(q, 1'b0, word);
        if (st) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    word[b*8 +: 8] = d[b*8 +: 8];
                end
            end
            ref_word[a[31:2]]          = word;
            ref_dirty[way][ad.set_idx] = 1'b1;
        end
    endtask

    function automatic logic [31:0] pick_addr(input int tag, input int set_idx);
        return {24'(tag), 4'(set_idx), 2'({$random(seed)} % 4), 2'b00};
    endfunction

    initial begin
        seed           = 79086;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        exp_miss       = 1'b0;
        exp_load       = 1'b0;
        exp_word       = '0;
        exp_fill_addr  = '0;
        exp_wb_addr    = '0;
        exp_wb_pending = 1'b0;
        ref_rr         = 0;
        for (int i = 0; i < `DC_NUM_WAYS; i++) begin
            for (int s = 0; s < `DC_NUM_SETS; s++) begin
                ref_valid[i][s] = 1'b0;
                ref_dirty[i][s] = 1'b0;
                ref_tag[i][s]   = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle cycle before the first request
        @(posedge clk);
        #1;

        // Cold miss, refill, then stores and back-to-back loads
        access(1'b0, 4'h0, 32'h0000_1230, '0);
        access(1'b1, 4'(0 + $random(seed)), 32'h0000_1230, $random(seed));
        access(1'b0, 4'h0, 32'h0000_1230, '0);
        access(1'b1, 4'(0 + $random(seed)), 32'h0000_1234, $random(seed));
        @(posedge clk);
        #1;
        access(1'b0, 4'h0, 32'h0000_1234, '0);

        // Three tags in set 5 so that the dirty line gets evicted
        access(1'b0, 4'h0, 32'h0000_0A50, '0);
        access(1'b0, 4'h0, 32'h0001_0A50, '0);
        access(1'b1, 4'hF, 32'h0000_0A54, $random(seed));
        access(1'b0, 4'h0, 32'h0002_0A58, '0);
        access(1'b0, 4'h0, 32'h0000_0A54, '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            access(1'(0 + $random(seed)), 4'(0 + $random(seed)),
                   pick_addr({$random(seed)} % 4, {$random(seed)} % 4), $random(seed));
        end

        // Last response arrives one cycle after the last request
        @(posedge clk);
        #1;

        // Memory holds every word that no dirty line still shadows
        foreach (ref_word[k]) begin
            if (!line_dirty({k, 2'b00})) begin
                assert (mem0.peek({k, 2'b00}) == ref_word[k])
                    else note_error("memory word differs from reference model");
            end
        end

        $display("Done: %0d requests, %0d errors", req_count, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_top.f */
+incdir+.
dcache_pkg.sv
dcache_tags.sv
dcache_lines.sv
dcache_store_merge.sv
dcache_burst_data.sv
dcache_ctrl.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv
